/* ctimer_pkg.sv */
/*
 * Shared definitions for the chained counter-timer pair
 * Word, address and byte-enable types
 * Register target enum used by the bus decoder
 * Address window, register offsets and configuration bit positions
 */

package ctimer_pkg;

    // Data, reload and count values
    typedef logic [31:0] ctimer_word_t;
    // Bus address
    typedef logic [31:0] ctimer_adr_t;
    // One enable per byte lane
    typedef logic [3:0]  ctimer_be_t;

    // Decoded register target
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_LO_CFG,
        SEL_LO_VAL,
        SEL_LO_DAT,
        SEL_HI_CFG,
        SEL_HI_VAL,
        SEL_HI_DAT
    } ctimer_sel_t;

    // 256 byte window
    localparam ctimer_adr_t CTIMER_BASE     = 32'h2400_0000;
    localparam ctimer_adr_t CTIMER_WIN_MASK = 32'hffff_ff00;

    // Low word registers
    localparam logic [7:0] OFS_LO_CFG = 8'h00;
    localparam logic [7:0] OFS_LO_VAL = 8'h04;   // Reload
    localparam logic [7:0] OFS_LO_DAT = 8'h08;   // Current count
    // High word registers
    localparam logic [7:0] OFS_HI_CFG = 8'h10;
    localparam logic [7:0] OFS_HI_VAL = 8'h14;
    localparam logic [7:0] OFS_HI_DAT = 8'h18;

    // Configuration register fields
    localparam int unsigned CFG_ENABLE  = 0;
    localparam int unsigned CFG_ONESHOT = 1;    // 1 one-shot, 0 continuous
    localparam int unsigned CFG_UPDOWN  = 2;    // 1 up, 0 down
    localparam int unsigned CFG_CHAIN   = 3;
    localparam int unsigned CFG_IRQENA  = 4;

endpackage

/* ctimer_ctrl_if.sv */
/*
 * Control bundle between one register block and its count engine
 * Configuration bits and reload value towards the core
 * Data register write path towards the core
 * Current count back to the register block
 */

interface ctimer_ctrl_if;
    import ctimer_pkg::*;

    logic         enable;      // Timer running
    logic         oneshot;
    logic         updown;      // Count direction, 1 is up
    logic         chain;       // Part of the 64-bit pair
    logic         irq_ena;
    ctimer_word_t reload;      // Terminal or start value
    ctimer_be_t   dat_we;      // Byte writes to the count
    ctimer_word_t dat_di;
    ctimer_word_t value_cur;   // Live count

    // Register side
    modport regs (
        output enable, oneshot, updown, chain, irq_ena, reload,
        output dat_we, dat_di,
        input  value_cur
    );

    // Count engine side
    modport core (
        input  enable, oneshot, updown, chain, irq_ena, reload,
        input  dat_we, dat_di,
        output value_cur
    );

endinterface

/* ctimer_bus_decode.sv */
/*
 * Wishbone-style register port of the timer pair
 * Window check and offset decode into a register target
 * Byte-enable gating of writes per register group
 * Same-cycle read-data mux and ack
 */

module ctimer_bus_decode (
    input  ctimer_pkg::ctimer_adr_t  wb_adr_i,
    input  ctimer_pkg::ctimer_word_t wb_dat_i,
    input  ctimer_pkg::ctimer_be_t   wb_sel_i,
    input  logic                     wb_we_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  ctimer_pkg::ctimer_word_t lo_cfg_rd_i,
    input  ctimer_pkg::ctimer_word_t lo_val_rd_i,
    input  ctimer_pkg::ctimer_word_t lo_dat_rd_i,
    input  ctimer_pkg::ctimer_word_t hi_cfg_rd_i,
    input  ctimer_pkg::ctimer_word_t hi_val_rd_i,
    input  ctimer_pkg::ctimer_word_t hi_dat_rd_i,
    output logic                     wb_ack_o,
    output ctimer_pkg::ctimer_word_t wb_dat_o,
    output logic                     lo_cfg_we_o,
    output logic                     hi_cfg_we_o,
    output ctimer_pkg::ctimer_be_t   lo_val_we_o,
    output ctimer_pkg::ctimer_be_t   hi_val_we_o,
    output ctimer_pkg::ctimer_be_t   lo_dat_we_o,
    output ctimer_pkg::ctimer_be_t   hi_dat_we_o,
    output ctimer_pkg::ctimer_word_t wdata_o
);
    import ctimer_pkg::*;

    logic        valid;
    logic        in_win;
    ctimer_be_t  be_wr;    // Byte lanes of a write
    ctimer_sel_t sel;

    assign valid    = wb_stb_i & wb_cyc_i;
    assign in_win   = (wb_adr_i & CTIMER_WIN_MASK) == CTIMER_BASE;
    assign wb_ack_o = valid & in_win;          // No wait states
    assign be_wr    = wb_sel_i & {4{wb_we_i}};
    assign wdata_o  = wb_dat_i;                // Shared by all registers

    always_comb begin
        sel = SEL_NONE;
        if (valid && in_win) begin
            case (wb_adr_i[7:0])
                OFS_LO_CFG: sel = SEL_LO_CFG;
                OFS_LO_VAL: sel = SEL_LO_VAL;
                OFS_LO_DAT: sel = SEL_LO_DAT;
                OFS_HI_CFG: sel = SEL_HI_CFG;
                OFS_HI_VAL: sel = SEL_HI_VAL;
                OFS_HI_DAT: sel = SEL_HI_DAT;
                default:    sel = SEL_NONE;    // Hole in the map
            endcase
        end
    end

    // Config only listens to lane 0
    assign lo_cfg_we_o = (sel == SEL_LO_CFG) & be_wr[0];
    assign hi_cfg_we_o = (sel == SEL_HI_CFG) & be_wr[0];
    assign lo_val_we_o = (sel == SEL_LO_VAL) ? be_wr : '0;
    assign hi_val_we_o = (sel == SEL_HI_VAL) ? be_wr : '0;
    assign lo_dat_we_o = (sel == SEL_LO_DAT) ? be_wr : '0;
    assign hi_dat_we_o = (sel == SEL_HI_DAT) ? be_wr : '0;

    always_comb begin
        case (sel)
            SEL_LO_CFG: wb_dat_o = lo_cfg_rd_i;
            SEL_LO_VAL: wb_dat_o = lo_val_rd_i;
            SEL_LO_DAT: wb_dat_o = lo_dat_rd_i;
            SEL_HI_CFG: wb_dat_o = hi_cfg_rd_i;
            SEL_HI_VAL: wb_dat_o = hi_val_rd_i;
            SEL_HI_DAT: wb_dat_o = hi_dat_rd_i;
            default:    wb_dat_o = '0;         // Unused offsets read zero
        endcase
    end

    // At most one register group written per access
    always_comb begin
        assert ($onehot0({lo_cfg_we_o, hi_cfg_we_o, |lo_val_we_o, |hi_val_we_o,
                          |lo_dat_we_o, |hi_dat_we_o}))
            else $error("bus_decode: overlapping write enables");
    end

endmodule

/* ctimer_regs.sv */
/*
 * Register block of one timer
 * Five configuration bits written from byte lane 0
 * Reload register with per-byte write enables
 * Data write path passed on to the core, live count read back
 */

module ctimer_regs (
    input  logic                     clkin,
    input  logic                     resetn,
    input  logic                     cfg_we_i,
    input  ctimer_pkg::ctimer_be_t   val_we_i,
    input  ctimer_pkg::ctimer_be_t   dat_we_i,
    input  ctimer_pkg::ctimer_word_t wdata_i,
    output ctimer_pkg::ctimer_word_t cfg_rd_o,
    output ctimer_pkg::ctimer_word_t val_rd_o,
    output ctimer_pkg::ctimer_word_t dat_rd_o,
    ctimer_ctrl_if.regs              ctrl
);
    import ctimer_pkg::*;

    logic [4:0]   cfg_q;       // irq_ena, chain, updown, oneshot, enable
    ctimer_word_t reload_q;

    // Configuration bits
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            cfg_q <= '0;
        end else if (cfg_we_i) begin
            cfg_q <= wdata_i[CFG_IRQENA:CFG_ENABLE];
        end
    end

    assign ctrl.enable  = cfg_q[CFG_ENABLE];
    assign ctrl.oneshot = cfg_q[CFG_ONESHOT];
    assign ctrl.updown  = cfg_q[CFG_UPDOWN];
    assign ctrl.chain   = cfg_q[CFG_CHAIN];
    assign ctrl.irq_ena = cfg_q[CFG_IRQENA];

    // Reload value, any mix of byte lanes
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            reload_q <= '0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (val_we_i[b]) begin
                    reload_q[8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign ctrl.reload = reload_q;

    // Count override handled inside the core
    assign ctrl.dat_we = dat_we_i;
    assign ctrl.dat_di = wdata_i;

    // Readback
    assign cfg_rd_o = {27'd0, cfg_q};
    assign val_rd_o = reload_q;
    assign dat_rd_o = ctrl.value_cur;

endmodule

/* ctimer_core_low.sv */
/*
 * Count engine of the low word
 * Standalone up or down count, one-shot or continuous
 * In chain mode free-running, one-cycle carry strobe at each wrap
 * Stop follows the high word while chained, irq on stop rise
 */

module ctimer_core_low (
    input  logic         clkin,
    input  logic         resetn,
    ctimer_ctrl_if.core  ctrl,
    input  logic         stop_hi_i,    // High word reached its end
    output logic         strobe_o,     // Carry into the high word
    output logic         stop_o,
    output logic         irq_o,
    output logic         enable_o      // Gates the chained high word
);
    import ctimer_pkg::*;

    ctimer_word_t value_q;
    ctimer_word_t term;        // Last value of a run
    ctimer_word_t start;       // First value of a run
    ctimer_word_t next;        // One step on
    logic         lastenable;
    logic         stop_d;      // Stop one cycle back, for irq edge

    assign term     = ctrl.updown ? ctrl.reload : '0;
    assign start    = ctrl.updown ? '0 : ctrl.reload;
    assign next     = ctrl.updown ? value_q + 32'd1 : value_q - 32'd1;
    assign enable_o = ctrl.enable;

    assign ctrl.value_cur = value_q;

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_q    <= '0;
            stop_o     <= 1'b0;
            strobe_o   <= 1'b0;
            irq_o      <= 1'b0;
            stop_d     <= 1'b0;
            lastenable <= 1'b0;
        end else begin
            lastenable <= ctrl.enable;
            stop_d     <= stop_o;
            irq_o      <= ctrl.irq_ena & stop_o & ~stop_d;   // One cycle after rise
            strobe_o   <= 1'b0;                              // Pulse by default

            if (ctrl.dat_we != '0) begin
                // Bus override wins over counting
                for (int b = 0; b < 4; b++) begin
                    if (ctrl.dat_we[b]) begin
                        value_q[8*b +: 8] <= ctrl.dat_di[8*b +: 8];
                    end
                end
            end else if (ctrl.enable) begin
                if (!lastenable) begin
                    value_q <= start;                        // Fresh start
                    stop_o  <= 1'b0;
                end else if (ctrl.chain) begin
                    stop_o <= stop_hi_i;                     // Pair stops together
                    if (value_q == term) begin
                        // Last lap of a one-shot pair parks here
                        if (!(stop_hi_i && ctrl.oneshot) && !strobe_o) begin
                            value_q  <= start;
                            strobe_o <= 1'b1;
                        end
                    end else begin
                        value_q <= next;
                    end
                end else if (value_q == term) begin
                    if (ctrl.oneshot) begin
                        stop_o <= 1'b1;                      // Hold at end
                    end else begin
                        value_q <= start;                    // Wrap
                        stop_o  <= 1'b0;
                    end
                end else begin
                    value_q <= next;
                    stop_o  <= (next == term);               // High on the last value
                end
            end else begin
                stop_o <= 1'b0;
            end
        end
    end

    // A carry is a single pulse
    assert property (@(posedge clkin) disable iff (!resetn) strobe_o |=> !strobe_o)
        else $error("core_low: strobe held for two cycles");

endmodule

/* ctimer_core_high.sv */
/*
 * Count engine of the high word
 * Standalone behaviour same as the low word
 * Chained it steps on the low word carry and is gated by its enable
 * Stop checked on the value being stepped to, irq on stop rise
 */

module ctimer_core_high (
    input  logic         clkin,
    input  logic         resetn,
    ctimer_ctrl_if.core  ctrl,
    input  logic         strobe_i,      // Carry from the low word
    input  logic         stop_in_i,     // Low word stop
    input  logic         enable_in_i,   // Low word enable
    output logic         stop_o,
    output logic         irq_o
);
    import ctimer_pkg::*;

    ctimer_word_t value_q;
    ctimer_word_t term;
    ctimer_word_t start;
    ctimer_word_t next;        // Plus one up, minus one down
    logic         loc_enable;
    logic         lastenable;
    logic         stop_d;

    assign term  = ctrl.updown ? ctrl.reload : '0;
    assign start = ctrl.updown ? '0 : ctrl.reload;
    assign next  = ctrl.updown ? value_q + 32'd1 : value_q - 32'd1;

    // Chained high word only runs with the low word
    assign loc_enable = ctrl.chain ? (ctrl.enable & enable_in_i) : ctrl.enable;

    assign ctrl.value_cur = value_q;

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_q    <= '0;
            stop_o     <= 1'b0;
            irq_o      <= 1'b0;
            stop_d     <= 1'b0;
            lastenable <= 1'b0;
        end else begin
            lastenable <= loc_enable;
            stop_d     <= stop_o;
            irq_o      <= ctrl.irq_ena & stop_o & ~stop_d;

            if (ctrl.dat_we != '0) begin
                for (int b = 0; b < 4; b++) begin
                    if (ctrl.dat_we[b]) begin
                        value_q[8*b +: 8] <= ctrl.dat_di[8*b +: 8];
                    end
                end
            end else if (loc_enable) begin
                if (!lastenable) begin
                    value_q <= start;
                    stop_o  <= 1'b0;
                end else if (ctrl.chain) begin
                    // Stop together with the step onto the terminal value
                    if (strobe_i && (next == term)) begin
                        stop_o <= 1'b1;
                    end
                    if (stop_in_i && !ctrl.oneshot) begin
                        value_q <= start;                // Pair restarts
                        stop_o  <= 1'b0;
                    end else if (strobe_i) begin
                        value_q <= next;
                    end
                end else if (value_q == term) begin
                    if (ctrl.oneshot) begin
                        stop_o <= 1'b1;
                    end else begin
                        value_q <= start;
                        stop_o  <= 1'b0;
                    end
                end else begin
                    value_q <= next;
                    stop_o  <= (next == term);
                end
            end else begin
                stop_o <= 1'b0;                          // Idle timer never stopped
            end
        end
    end

    // Interrupt only right after a fresh stop
    assert property (@(posedge clkin) disable iff (!resetn)
                     irq_o |-> $past(stop_o) && !$past(stop_o, 2))
        else $error("core_high: irq without a stop rise");

endmodule

/* ctimer_pair_top.sv */
/*
 * Top level of the chained timer pair
 * Bus decoder, two register blocks and the low and high count engines
 * Carry, stop and enable wired between the two cores
 */

module ctimer_pair_top (
    input  logic                     clkin,
    input  logic                     resetn,
    input  ctimer_pkg::ctimer_adr_t  wb_adr_i,
    input  ctimer_pkg::ctimer_word_t wb_dat_i,
    input  ctimer_pkg::ctimer_be_t   wb_sel_i,
    input  logic                     wb_we_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    output logic                     wb_ack_o,
    output ctimer_pkg::ctimer_word_t wb_dat_o,
    output logic                     stop_lo_o,
    output logic                     stop_hi_o,
    output logic                     irq_lo_o,
    output logic                     irq_hi_o
);
    import ctimer_pkg::*;

    logic         lo_cfg_we, hi_cfg_we;
    ctimer_be_t   lo_val_we, hi_val_we;
    ctimer_be_t   lo_dat_we, hi_dat_we;
    ctimer_word_t wdata;
    ctimer_word_t lo_cfg_rd, lo_val_rd, lo_dat_rd;
    ctimer_word_t hi_cfg_rd, hi_val_rd, hi_dat_rd;
    logic         strobe_lo;   // Low wrap carry
    logic         enable_lo;

    ctimer_ctrl_if lo_ctrl ();
    ctimer_ctrl_if hi_ctrl ();

    ctimer_bus_decode u_decode (
        .wb_adr_i, .wb_dat_i, .wb_sel_i, .wb_we_i, .wb_cyc_i, .wb_stb_i,
        .lo_cfg_rd_i (lo_cfg_rd), .lo_val_rd_i (lo_val_rd), .lo_dat_rd_i (lo_dat_rd),
        .hi_cfg_rd_i (hi_cfg_rd), .hi_val_rd_i (hi_val_rd), .hi_dat_rd_i (hi_dat_rd),
        .wb_ack_o, .wb_dat_o,
        .lo_cfg_we_o (lo_cfg_we), .hi_cfg_we_o (hi_cfg_we),
        .lo_val_we_o (lo_val_we), .hi_val_we_o (hi_val_we),
        .lo_dat_we_o (lo_dat_we), .hi_dat_we_o (hi_dat_we),
        .wdata_o     (wdata)
    );

    ctimer_regs u_regs_lo (
        .clkin, .resetn,
        .cfg_we_i (lo_cfg_we), .val_we_i (lo_val_we), .dat_we_i (lo_dat_we),
        .wdata_i  (wdata),
        .cfg_rd_o (lo_cfg_rd), .val_rd_o (lo_val_rd), .dat_rd_o (lo_dat_rd),
        .ctrl     (lo_ctrl.regs)
    );

    ctimer_regs u_regs_hi (
        .clkin, .resetn,
        .cfg_we_i (hi_cfg_we), .val_we_i (hi_val_we), .dat_we_i (hi_dat_we),
        .wdata_i  (wdata),
        .cfg_rd_o (hi_cfg_rd), .val_rd_o (hi_val_rd), .dat_rd_o (hi_dat_rd),
        .ctrl     (hi_ctrl.regs)
    );

    ctimer_core_low u_core_lo (
        .clkin, .resetn,
        .ctrl      (lo_ctrl.core),
        .stop_hi_i (stop_hi_o),
        .strobe_o  (strobe_lo),
        .stop_o    (stop_lo_o),
        .irq_o     (irq_lo_o),
        .enable_o  (enable_lo)
    );

    ctimer_core_high u_core_hi (
        .clkin, .resetn,
        .ctrl        (hi_ctrl.core),
        .strobe_i    (strobe_lo),
        .stop_in_i   (stop_lo_o),
        .enable_in_i (enable_lo),
        .stop_o      (stop_hi_o),
        .irq_o       (irq_hi_o)
    );

endmodule

/* tb_ctimer_pair.sv */
/*
 * Testbench of the chained timer pair
 * Bus access tasks, stop waits with timeouts, value compares
 * Concurrent checks on ack and both irq pulses
 * Readback, one-shot down, continuous period, 64-bit chain, override
 */

module tb_ctimer_pair;
    import ctimer_pkg::*;

    localparam int TIMEOUT_CYC = 400;

    logic         clkin;
    logic         resetn;
    ctimer_adr_t  wb_adr_i;
    ctimer_word_t wb_dat_i;
    ctimer_be_t   wb_sel_i;
    logic         wb_we_i;
    logic         wb_cyc_i;
    logic         wb_stb_i;
    logic         wb_ack_o;
    ctimer_word_t wb_dat_o;
    logic         stop_lo_o, stop_hi_o, irq_lo_o, irq_hi_o;
    int           errors = 0;
    int           checks = 0;

    ctimer_pair_top DUT (.*);

    initial begin
        clkin = 1'b0;
        forever #20 clkin = ~clkin;
    end

    task automatic check_eq(input string name, input ctimer_word_t exp, input ctimer_word_t got);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("ERROR %0t %s expected %h seen %h", $time, name, exp, got);
        end
    endtask

    // Starts at a falling edge, ends on the next one with the bus idle
    task automatic drive_access(input logic [7:0] ofs, input logic we, input ctimer_word_t wdat,
                                input ctimer_be_t be, output ctimer_word_t rdat);
        int n = 0;
        wb_adr_i = {CTIMER_BASE[31:8], ofs};
        wb_we_i  = we;
        wb_dat_i = wdat;
        wb_sel_i = be;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        #10;                                       // Mid low phase, all settled
        while (!wb_ack_o && n < TIMEOUT_CYC) begin
            @(negedge clkin);
            #10;
            n++;
        end
        if (!wb_ack_o) begin
            errors++;
            $display("No ack at offset %h within %0d cycles", ofs, TIMEOUT_CYC);
        end else begin
            check_eq("ack delay", 32'd0, ctimer_word_t'(n));   // Same-cycle ack
        end
        rdat = wb_dat_o;
        @(negedge clkin);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] ofs, input ctimer_word_t data, input ctimer_be_t be);
        ctimer_word_t unused;
        drive_access(ofs, 1'b1, data, be, unused);
    endtask

    task automatic bus_read(input logic [7:0] ofs, output ctimer_word_t data);
        drive_access(ofs, 1'b0, 32'd0, 4'hf, data);
    endtask

    // Count falling edges until the chosen stop reaches the level
    task automatic wait_stop(input logic hi, input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clkin);
            cycles++;
        end while (((hi ? stop_hi_o : stop_lo_o) != level) && cycles < TIMEOUT_CYC);
        if ((hi ? stop_hi_o : stop_lo_o) != level) begin
            errors++;
            $display("Timeout waiting for stop_%s_o to reach %b", hi ? "hi" : "lo", level);
        end
    endtask

    // Ack only for a valid access inside the 256 byte window
    assert property (@(posedge clkin) disable iff (!resetn)
        wb_ack_o == (wb_cyc_i && wb_stb_i && wb_adr_i[31:8] == 24'h240000))
    else begin
        errors++;
        $display("ERROR %0t wb_ack_o expected %b seen %b", $time, !wb_ack_o, wb_ack_o);
    end

    // Low irq is one cycle, one clock after the stop rise
    assert property (@(posedge clkin) disable iff (!resetn)
        irq_lo_o |-> $past(stop_lo_o) && !$past(stop_lo_o, 2) ##1 !irq_lo_o)
    else begin
        errors++;
        $display("irq_lo_o pulse at %0t does not follow a stop rise by one clock", $time);
    end

    // Same shape for the high irq
    assert property (@(posedge clkin) disable iff (!resetn)
        irq_hi_o |-> $past(stop_hi_o) && !$past(stop_hi_o, 2) ##1 !irq_hi_o)
    else begin
        errors++;
        $display("irq_hi_o pulse at %0t does not follow a stop rise by one clock", $time);
    end

    initial begin
        ctimer_word_t rd, exp, base, nv, prev, x;
        ctimer_be_t   be;
        logic [7:0]   ofs;
        logic         s;
        int           r, rl, rh, c1, c2, since, steps;
        rd       = $urandom(32'he3a65117);
        resetn   = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        repeat (8) @(negedge clkin);
        resetn = 1'b1;
        @(negedge clkin);

        // Config readback, enable held low, lane 0 gating
        for (int i = 0; i < 2; i++) begin
            ofs = i[0] ? OFS_HI_CFG : OFS_LO_CFG;
            x   = $urandom & 32'hffff_fffe;
            bus_write(ofs, x, 4'hf);
            bus_read(ofs, rd);
            check_eq("cfg readback", x & 32'h1f, rd);
            bus_write(ofs, ~x & 32'hffff_fffe, 4'he);
            bus_read(ofs, rd);
            check_eq("cfg lane 0 gate", x & 32'h1f, rd);
        end
        // Reload byte lanes
        for (int i = 0; i < 4; i++) begin
            ofs  = i[0] ? OFS_HI_VAL : OFS_LO_VAL;
            base = $urandom;
            nv   = $urandom;
            be   = ctimer_be_t'($urandom);
            bus_write(ofs, base, 4'hf);
            bus_write(ofs, nv, be);
            for (int b = 0; b < 4; b++) begin
                exp[8*b +: 8] = be[b] ? nv[8*b +: 8] : base[8*b +: 8];
            end
            bus_read(ofs, rd);
            check_eq("reload bytes", exp, rd);
        end
        bus_read(8'h0c, rd);
        check_eq("unused offset", 32'd0, rd);

        // Low one-shot down count with irq
        r = int'($urandom % 8) + 3;
        bus_write(OFS_LO_VAL, ctimer_word_t'(r), 4'hf);
        bus_write(OFS_LO_CFG, 32'h13, 4'hf);       // enable, oneshot, irq_ena
        wait_stop(1'b0, 1'b1, c1);
        check_eq("irq_lo_o", 32'd0, ctimer_word_t'(irq_lo_o));
        @(negedge clkin);
        check_eq("irq_lo_o", 32'd1, ctimer_word_t'(irq_lo_o));
        @(negedge clkin);
        check_eq("irq_lo_o", 32'd0, ctimer_word_t'(irq_lo_o));
        check_eq("stop_lo_o", 32'd1, ctimer_word_t'(stop_lo_o));   // Held
        bus_read(OFS_LO_DAT, rd);
        check_eq("lo_dat at end", 32'd0, rd);

        // High standalone continuous up, period reload+1
        r = int'($urandom % 8) + 2;
        bus_write(OFS_HI_VAL, ctimer_word_t'(r), 4'hf);
        bus_write(OFS_HI_CFG, 32'h05, 4'hf);       // enable, up
        wait_stop(1'b1, 1'b1, c1);
        for (int k = 0; k < 3; k++) begin
            wait_stop(1'b1, 1'b0, c1);
            wait_stop(1'b1, 1'b1, c2);
            check_eq("stop_hi_o period", ctimer_word_t'(r + 1), ctimer_word_t'(c1 + c2));
        end
        bus_write(OFS_HI_CFG, 32'h0, 4'hf);
        bus_write(OFS_LO_CFG, 32'h0, 4'hf);

        // Chained 64-bit one-shot up count
        rl = int'($urandom % 4) + 1;
        rh = int'($urandom % 3) + 1;
        bus_write(OFS_LO_VAL, ctimer_word_t'(rl), 4'hf);
        bus_write(OFS_HI_VAL, ctimer_word_t'(rh), 4'hf);
        bus_write(OFS_HI_CFG, 32'h1f, 4'hf);       // Waits for the low enable, irq on
        bus_write(OFS_LO_CFG, 32'h0f, 4'hf);
        @(negedge clkin);                           // Both words at zero now
        prev  = '0;
        since = 0;
        steps = 0;
        c1    = 0;
        do begin
            s = stop_hi_o;                          // Same state the read sees
            bus_read(OFS_HI_DAT, rd);
            check_eq("stop_hi_o", ctimer_word_t'(rd == ctimer_word_t'(rh)), ctimer_word_t'(s));
            if (rd != prev) begin
                check_eq("hi_dat step", prev + 32'd1, rd);
                if (steps > 0) begin
                    check_eq("low wrap spacing", ctimer_word_t'(rl + 1), ctimer_word_t'(since));
                end
                steps++;
                since = 0;
            end
            prev = rd;
            since++;
            c1++;
        end while (!s && c1 < TIMEOUT_CYC);
        if (!s) begin
            errors++;
            $display("Timeout waiting for the chained pair to stop");
        end
        check_eq("hi wraps seen", ctimer_word_t'(rh), ctimer_word_t'(steps));
        check_eq("irq_hi_o", 32'd1, ctimer_word_t'(irq_hi_o));   // One clock after the stop
        wait_stop(1'b0, 1'b1, c2);                  // Low stop follows the high one
        repeat (2 * rl + 4) @(negedge clkin);
        bus_read(OFS_HI_DAT, rd);
        check_eq("hi_dat parked", ctimer_word_t'(rh), rd);

        // Override mid-count, then disable the pair
        x = 32'h0001_0000 | ($urandom & 32'h0000_ffff);
        bus_write(OFS_LO_DAT, x, 4'hf);
        bus_read(OFS_LO_DAT, rd);
        check_eq("lo_dat override", x, rd);
        bus_read(OFS_LO_DAT, rd);
        check_eq("lo_dat counting", x + 32'd1, rd);
        check_eq("stop_lo_o", 32'd1, ctimer_word_t'(stop_lo_o));
        check_eq("stop_hi_o", 32'd1, ctimer_word_t'(stop_hi_o));
        bus_write(OFS_LO_CFG, 32'h0e, 4'hf);       // Low enable off gates the high word
        @(negedge clkin);                           // Stops drop on the edge after the write
        check_eq("stop_lo_o", 32'd0, ctimer_word_t'(stop_lo_o));
        check_eq("stop_hi_o", 32'd0, ctimer_word_t'(stop_hi_o));

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
ctimer_pkg.sv
ctimer_ctrl_if.sv
ctimer_bus_decode.sv
ctimer_regs.sv
ctimer_core_low.sv
ctimer_core_high.sv
ctimer_pair_top.sv
tb_ctimer_pair.sv

/* run.sh */
#!/bin/sh
# Build and run the timer pair testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -f tb.f --top-module tb_ctimer_pair -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$"
